// ==== design/cpu6_dp_pkg.sv ====
`default_nettype none

package cpu6_dp_pkg;

   // datapath
   localparam int XLEN    = 32;
   localparam int NREGS   = 16;
   localparam int RADDR_W = $clog2(NREGS);

   // alu function codes
   localparam int ALUOP_W = 3;

   localparam logic [ALUOP_W-1:0] ALU_ADD = 3'd0;
   localparam logic [ALUOP_W-1:0] ALU_SUB = 3'd1; // adder with inverted b and carry-in
   localparam logic [ALUOP_W-1:0] ALU_AND = 3'd2;
   localparam logic [ALUOP_W-1:0] ALU_OR  = 3'd3;
   localparam logic [ALUOP_W-1:0] ALU_XOR = 3'd4;
   localparam logic [ALUOP_W-1:0] ALU_SLT = 3'd5; // signed compare through the subtractor

endpackage

`default_nettype wire

// ==== design/cpu6_isa_pkg.sv ====
`default_nettype none

package cpu6_isa_pkg;

   localparam int OPC_W = 4;
   localparam int IMM_W = 20;

   // lui places the immediate above this bit
   localparam int LUI_SHIFT = 12;

   // one 32-bit word, two views
   // opcode, rd and rs1 sit in the same place in both formats
   typedef union packed {
      struct packed {
         logic [OPC_W-1:0] opcode;
         logic [3:0]       rd;
         logic [3:0]       rs1;
         logic [3:0]       rs2;
         logic [15:0]      unused;
      } r;
      struct packed {
         logic [OPC_W-1:0] opcode;
         logic [3:0]       rd;
         logic [3:0]       rs1;
         logic [IMM_W-1:0] imm; // sign extended except for lui
      } i;
   } instr_t;

   // register format
   localparam logic [OPC_W-1:0] OP_ADD  = 4'h0;
   localparam logic [OPC_W-1:0] OP_SUB  = 4'h1;
   localparam logic [OPC_W-1:0] OP_AND  = 4'h2;
   localparam logic [OPC_W-1:0] OP_OR   = 4'h3;
   localparam logic [OPC_W-1:0] OP_XOR  = 4'h4;
   localparam logic [OPC_W-1:0] OP_SLT  = 4'h5;
   localparam logic [OPC_W-1:0] OP_SLL  = 4'h6;
   localparam logic [OPC_W-1:0] OP_SRL  = 4'h7;
   localparam logic [OPC_W-1:0] OP_SRA  = 4'h8;

   // immediate format
   localparam logic [OPC_W-1:0] OP_ADDI = 4'h9;
   localparam logic [OPC_W-1:0] OP_SLLI = 4'ha; // shift amount in imm[4:0]
   localparam logic [OPC_W-1:0] OP_SRLI = 4'hb;
   localparam logic [OPC_W-1:0] OP_SRAI = 4'hc;
   localparam logic [OPC_W-1:0] OP_LUI  = 4'hd; // rs1 ignored

   // 4'he and 4'hf are reserved: result 0, no write-back

endpackage

`default_nettype wire

// ==== design/cpu6_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu6_regfile (
   input  logic                              clk,
   input  logic                              rst,
   input  logic [cpu6_dp_pkg::RADDR_W-1:0]   rs1_addr,
   input  logic [cpu6_dp_pkg::RADDR_W-1:0]   rs2_addr,
   input  logic                              wr_en,
   input  logic [cpu6_dp_pkg::RADDR_W-1:0]   wr_addr,
   input  logic [cpu6_dp_pkg::XLEN-1:0]      wr_data,
   output logic [cpu6_dp_pkg::XLEN-1:0]      rs1_data,
   output logic [cpu6_dp_pkg::XLEN-1:0]      rs2_data
);

   logic [cpu6_dp_pkg::XLEN-1:0] regs [cpu6_dp_pkg::NREGS];

   logic wr_hit;

   // r0 is hardwired, writes to it are dropped
   assign wr_hit = wr_en && (wr_addr != '0);

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < cpu6_dp_pkg::NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_hit) begin
         regs[wr_addr] <= wr_data;
      end
   end

   // combinational reads, a write on this edge shows up next cycle
   assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
   assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// ==== design/cpu6_shft.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu6_shft (
   input  logic [cpu6_dp_pkg::XLEN-1:0] rs1_data,
   input  logic [cpu6_dp_pkg::XLEN-1:0] rs2_data,   // amount in bits 4:0
   input  logic                         shft_lr,    // 1 left, 0 right
   input  logic                         shft_arith,
   output logic [cpu6_dp_pkg::XLEN-1:0] shft_out
);

   logic [1:0] shift16; // 16, 0
   logic [3:0] shift4;  // 12, 8, 4, 0
   logic [3:0] shift1;  // 3, 2, 1, 0

   logic [15:0] fill;

   logic [cpu6_dp_pkg::XLEN-1:0] lshift16;
   logic [cpu6_dp_pkg::XLEN-1:0] lshift4;
   logic [cpu6_dp_pkg::XLEN-1:0] lshift1;
   logic [cpu6_dp_pkg::XLEN-1:0] rshift16;
   logic [cpu6_dp_pkg::XLEN-1:0] rshift4;
   logic [cpu6_dp_pkg::XLEN-1:0] rshift1;

   assign fill = {16{shft_arith & rs1_data[31]}};

   // one-hot stage selects
   assign shift16[1] =  rs2_data[4];
   assign shift16[0] = ~rs2_data[4];

   assign shift4[0] = ~rs2_data[3] & ~rs2_data[2];
   assign shift4[1] = ~rs2_data[3] &  rs2_data[2];
   assign shift4[2] =  rs2_data[3] & ~rs2_data[2];
   assign shift4[3] =  rs2_data[3] &  rs2_data[2];

   assign shift1[0] = ~rs2_data[1] & ~rs2_data[0];
   assign shift1[1] = ~rs2_data[1] &  rs2_data[0];
   assign shift1[2] =  rs2_data[1] & ~rs2_data[0];
   assign shift1[3] =  rs2_data[1] &  rs2_data[0];

   // left shifter, zero fill
   assign lshift16 = ({32{shift16[1]}} & {rs1_data[15:0], 16'b0})
                   | ({32{shift16[0]}} & rs1_data);

   assign lshift4 = ({32{shift4[0]}} & lshift16)
                  | ({32{shift4[1]}} & {lshift16[27:0], 4'b0})
                  | ({32{shift4[2]}} & {lshift16[23:0], 8'b0})
                  | ({32{shift4[3]}} & {lshift16[19:0], 12'b0});

   assign lshift1 = ({32{shift1[0]}} & lshift4)
                  | ({32{shift1[1]}} & {lshift4[30:0], 1'b0})
                  | ({32{shift1[2]}} & {lshift4[29:0], 2'b0})
                  | ({32{shift1[3]}} & {lshift4[28:0], 3'b0});

   // right shifter, fill comes in from the top
   assign rshift16 = ({32{shift16[1]}} & {fill[15:0], rs1_data[31:16]})
                   | ({32{shift16[0]}} & rs1_data);

   assign rshift4 = ({32{shift4[0]}} & rshift16)
                  | ({32{shift4[1]}} & {fill[15:12], rshift16[31:4]})
                  | ({32{shift4[2]}} & {fill[15:8], rshift16[31:8]})
                  | ({32{shift4[3]}} & {fill[15:4], rshift16[31:12]});

   assign rshift1 = ({32{shift1[0]}} & rshift4)
                  | ({32{shift1[1]}} & {fill[15], rshift4[31:1]})
                  | ({32{shift1[2]}} & {fill[15:14], rshift4[31:2]})
                  | ({32{shift1[3]}} & {fill[15:13], rshift4[31:3]});

   assign shft_out = shft_lr ? lshift1 : rshift1;

endmodule

`default_nettype wire

// ==== design/cpu6_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu6_alu (
   input  logic [cpu6_dp_pkg::XLEN-1:0]    alu_a,
   input  logic [cpu6_dp_pkg::XLEN-1:0]    alu_b,
   input  logic [cpu6_dp_pkg::ALUOP_W-1:0] alu_op,
   output logic [cpu6_dp_pkg::XLEN-1:0]    alu_out
);

   localparam int MSB = cpu6_dp_pkg::XLEN - 1;

   logic                         sub;
   logic [cpu6_dp_pkg::XLEN-1:0] b_op;
   logic [cpu6_dp_pkg::XLEN-1:0] cin;
   logic [cpu6_dp_pkg::XLEN-1:0] sum;
   logic                         ovf;
   logic                         lt;

   // slt subtracts too
   assign sub = (alu_op == cpu6_dp_pkg::ALU_SUB) || (alu_op == cpu6_dp_pkg::ALU_SLT);

   assign b_op = sub ? ~alu_b : alu_b;
   assign cin  = {{(cpu6_dp_pkg::XLEN-1){1'b0}}, sub};

   // the one adder
   assign sum = alu_a + b_op + cin;

   // signed overflow: like-signed inputs, result sign flipped
   assign ovf = (alu_a[MSB] == b_op[MSB]) && (sum[MSB] != alu_a[MSB]);
   assign lt  = sum[MSB] ^ ovf;

   always_comb begin
      case (alu_op)
         cpu6_dp_pkg::ALU_ADD,
         cpu6_dp_pkg::ALU_SUB: alu_out = sum;
         cpu6_dp_pkg::ALU_AND: alu_out = alu_a & alu_b;
         cpu6_dp_pkg::ALU_OR:  alu_out = alu_a | alu_b;
         cpu6_dp_pkg::ALU_XOR: alu_out = alu_a ^ alu_b;
         cpu6_dp_pkg::ALU_SLT: alu_out = {{(cpu6_dp_pkg::XLEN-1){1'b0}}, lt};
         default:              alu_out = '0; // unused codes
      endcase
   end

endmodule

`default_nettype wire

// ==== design/cpu6_exu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu6_exu (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              instr_valid,
   input  logic [31:0]                       instr,
   input  logic                              res_ready,
   input  logic [cpu6_dp_pkg::XLEN-1:0]      rs1_data,
   input  logic [cpu6_dp_pkg::XLEN-1:0]      rs2_data,
   input  logic [cpu6_dp_pkg::XLEN-1:0]      alu_out,
   input  logic [cpu6_dp_pkg::XLEN-1:0]      shft_out,
   output logic                              instr_ready,
   output logic                              res_valid,
   output logic [cpu6_dp_pkg::XLEN-1:0]      res_data,
   output logic [cpu6_dp_pkg::RADDR_W-1:0]   res_rd,
   output logic [cpu6_dp_pkg::RADDR_W-1:0]   rs1_addr,
   output logic [cpu6_dp_pkg::RADDR_W-1:0]   rs2_addr,
   output logic [cpu6_dp_pkg::XLEN-1:0]      alu_a,
   output logic [cpu6_dp_pkg::XLEN-1:0]      alu_b,
   output logic [cpu6_dp_pkg::ALUOP_W-1:0]   alu_op,
   output logic [cpu6_dp_pkg::XLEN-1:0]      shft_operand,
   output logic                              shft_lr,
   output logic                              shft_arith,
   output logic                              wr_en,
   output logic [cpu6_dp_pkg::RADDR_W-1:0]   wr_addr,
   output logic [cpu6_dp_pkg::XLEN-1:0]      wr_data
);

   cpu6_isa_pkg::instr_t ir;

   logic [cpu6_isa_pkg::OPC_W-1:0] opc;
   logic [cpu6_dp_pkg::XLEN-1:0]   imm_sext;
   logic [cpu6_dp_pkg::XLEN-1:0]   opnd_b;
   logic [cpu6_dp_pkg::XLEN-1:0]   result;
   logic                           is_imm;
   logic                           op_legal;
   logic                           accept;

   assign ir  = instr;
   assign opc = ir.r.opcode;

   assign rs1_addr = ir.r.rs1;
   assign rs2_addr = ir.r.rs2; // don't care for immediate forms

   assign imm_sext = {{(cpu6_dp_pkg::XLEN-cpu6_isa_pkg::IMM_W){ir.i.imm[cpu6_isa_pkg::IMM_W-1]}},
                      ir.i.imm};

   assign is_imm = (opc == cpu6_isa_pkg::OP_ADDI) || (opc == cpu6_isa_pkg::OP_SLLI) ||
                   (opc == cpu6_isa_pkg::OP_SRLI) || (opc == cpu6_isa_pkg::OP_SRAI);

   // second operand feeds both alu and shifter
   assign opnd_b       = is_imm ? imm_sext : rs2_data;
   assign alu_a        = rs1_data;
   assign alu_b        = opnd_b;
   assign shft_operand = opnd_b;

   assign shft_lr    = (opc == cpu6_isa_pkg::OP_SLL) || (opc == cpu6_isa_pkg::OP_SLLI);
   assign shft_arith = (opc == cpu6_isa_pkg::OP_SRA) || (opc == cpu6_isa_pkg::OP_SRAI);

   always_comb begin
      alu_op   = cpu6_dp_pkg::ALU_ADD;
      result   = alu_out;
      op_legal = 1'b1;
      case (opc)
         cpu6_isa_pkg::OP_ADD,
         cpu6_isa_pkg::OP_ADDI: alu_op = cpu6_dp_pkg::ALU_ADD;
         cpu6_isa_pkg::OP_SUB:  alu_op = cpu6_dp_pkg::ALU_SUB;
         cpu6_isa_pkg::OP_AND:  alu_op = cpu6_dp_pkg::ALU_AND;
         cpu6_isa_pkg::OP_OR:   alu_op = cpu6_dp_pkg::ALU_OR;
         cpu6_isa_pkg::OP_XOR:  alu_op = cpu6_dp_pkg::ALU_XOR;
         cpu6_isa_pkg::OP_SLT:  alu_op = cpu6_dp_pkg::ALU_SLT;
         cpu6_isa_pkg::OP_SLL, cpu6_isa_pkg::OP_SRL, cpu6_isa_pkg::OP_SRA,
         cpu6_isa_pkg::OP_SLLI, cpu6_isa_pkg::OP_SRLI, cpu6_isa_pkg::OP_SRAI:
            result = shft_out;
         cpu6_isa_pkg::OP_LUI:  result = imm_sext << cpu6_isa_pkg::LUI_SHIFT;
         default: begin
            result   = '0; // reserved
            op_legal = 1'b0;
         end
      endcase
   end

   assign instr_ready = ~res_valid | res_ready;
   assign accept      = instr_valid & instr_ready;

   // write-back at the acceptance edge, so the next instruction sees it
   assign wr_en   = accept && op_legal && (ir.r.rd != '0);
   assign wr_addr = ir.r.rd;
   assign wr_data = result;

   always_ff @(posedge clk) begin
      if (rst) begin
         res_valid <= 1'b0;
      end else if (instr_ready) begin
         res_valid <= instr_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         res_data <= result;
         res_rd   <= ir.r.rd;   // r0 still reported
      end
   end

endmodule

`default_nettype wire

// ==== design/cpu6_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu6_top (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              instr_valid,
   input  logic [31:0]                       instr,
   input  logic                              res_ready,
   output logic                              instr_ready,
   output logic                              res_valid,
   output logic [cpu6_dp_pkg::XLEN-1:0]      res_data,
   output logic [cpu6_dp_pkg::RADDR_W-1:0]   res_rd
);

   logic [cpu6_dp_pkg::RADDR_W-1:0] rs1_addr;
   logic [cpu6_dp_pkg::RADDR_W-1:0] rs2_addr;
   logic [cpu6_dp_pkg::RADDR_W-1:0] wr_addr;
   logic [cpu6_dp_pkg::XLEN-1:0]    rs1_data;
   logic [cpu6_dp_pkg::XLEN-1:0]    rs2_data;
   logic [cpu6_dp_pkg::XLEN-1:0]    wr_data;
   logic                            wr_en;

   logic [cpu6_dp_pkg::XLEN-1:0]    alu_a;
   logic [cpu6_dp_pkg::XLEN-1:0]    alu_b;
   logic [cpu6_dp_pkg::ALUOP_W-1:0] alu_op;
   logic [cpu6_dp_pkg::XLEN-1:0]    alu_out;

   logic [cpu6_dp_pkg::XLEN-1:0]    shft_operand;
   logic                            shft_lr;
   logic                            shft_arith;
   logic [cpu6_dp_pkg::XLEN-1:0]    shft_out;

   cpu6_exu u_exu (
      .clk          (clk),
      .rst          (rst),
      .instr_valid  (instr_valid),
      .instr        (instr),
      .res_ready    (res_ready),
      .rs1_data     (rs1_data),
      .rs2_data     (rs2_data),
      .alu_out      (alu_out),
      .shft_out     (shft_out),
      .instr_ready  (instr_ready),
      .res_valid    (res_valid),
      .res_data     (res_data),
      .res_rd       (res_rd),
      .rs1_addr     (rs1_addr),
      .rs2_addr     (rs2_addr),
      .alu_a        (alu_a),
      .alu_b        (alu_b),
      .alu_op       (alu_op),
      .shft_operand (shft_operand),
      .shft_lr      (shft_lr),
      .shft_arith   (shft_arith),
      .wr_en        (wr_en),
      .wr_addr      (wr_addr),
      .wr_data      (wr_data)
   );

   cpu6_regfile u_regfile (
      .clk      (clk),
      .rst      (rst),
      .rs1_addr (rs1_addr),
      .rs2_addr (rs2_addr),
      .wr_en    (wr_en),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data)
   );

   cpu6_alu u_alu (
      .alu_a   (alu_a),
      .alu_b   (alu_b),
      .alu_op  (alu_op),
      .alu_out (alu_out)
   );

   // shift amount comes from rs2 or the immediate
   cpu6_shft u_shft (
      .rs1_data   (rs1_data),
      .rs2_data   (shft_operand),
      .shft_lr    (shft_lr),
      .shft_arith (shft_arith),
      .shft_out   (shft_out)
   );

endmodule

`default_nettype wire

// ==== testbench/tb_cpu6_vectors.svh ====
// each entry holds the test name, instruction word, expected res_data and expected res_rd
// entries run in order and build on the register writes before them
task automatic load_vectors();
   // r1 gets the top bit set and r2 gets it clear
   add_vec("lui r1", imm_word(cpu6_isa_pkg::OP_LUI, 1, 0, 20'h87654), 32'h8765_4000, 1);
   add_vec("addi r1", imm_word(cpu6_isa_pkg::OP_ADDI, 1, 1, 20'h00321), 32'h8765_4321, 1);
   add_vec("lui r2 rs1 ignored", imm_word(cpu6_isa_pkg::OP_LUI, 2, 1, 20'h12345),
           32'h1234_5000, 2);
   add_vec("addi r2", imm_word(cpu6_isa_pkg::OP_ADDI, 2, 2, 20'h00678), 32'h1234_5678, 2);
   add_vec("addi r3 neg", imm_word(cpu6_isa_pkg::OP_ADDI, 3, 0, 20'hffffb), 32'hffff_fffb, 3);
   add_vec("addi r4", imm_word(cpu6_isa_pkg::OP_ADDI, 4, 0, 20'h00007), 32'd7, 4);

   add_vec("add", reg_word(cpu6_isa_pkg::OP_ADD, 5, 1, 2), 32'h9999_9999, 5);
   add_vec("sub", reg_word(cpu6_isa_pkg::OP_SUB, 6, 2, 1), 32'h8acf_1357, 6);
   add_vec("and", reg_word(cpu6_isa_pkg::OP_AND, 7, 1, 2), 32'h0224_4220, 7);
   add_vec("or", reg_word(cpu6_isa_pkg::OP_OR, 8, 1, 2), 32'h9775_5779, 8);
   add_vec("xor", reg_word(cpu6_isa_pkg::OP_XOR, 9, 1, 2), 32'h9551_1559, 9);
   add_vec("slt neg pos", reg_word(cpu6_isa_pkg::OP_SLT, 10, 3, 4), 32'd1, 10);
   add_vec("slt pos neg", reg_word(cpu6_isa_pkg::OP_SLT, 10, 4, 3), 32'd0, 10);
   add_vec("slt overflow", reg_word(cpu6_isa_pkg::OP_SLT, 10, 1, 2), 32'd1, 10);
   add_vec("slt pos true", reg_word(cpu6_isa_pkg::OP_SLT, 10, 4, 2), 32'd1, 10);
   add_vec("slt pos false", reg_word(cpu6_isa_pkg::OP_SLT, 10, 2, 4), 32'd0, 10);
   add_vec("slt neg pair", reg_word(cpu6_isa_pkg::OP_SLT, 11, 1, 3), 32'd1, 11);

   // register shifts take the amount from r12
   add_vec("amount 1", imm_word(cpu6_isa_pkg::OP_ADDI, 12, 0, 20'h00001), 32'd1, 12);
   add_vec("sll r1 1", reg_word(cpu6_isa_pkg::OP_SLL, 13, 1, 12), 32'h0eca_8642, 13);
   add_vec("srl r1 1", reg_word(cpu6_isa_pkg::OP_SRL, 13, 1, 12), 32'h43b2_a190, 13);
   add_vec("sra r1 1", reg_word(cpu6_isa_pkg::OP_SRA, 13, 1, 12), 32'hc3b2_a190, 13);
   add_vec("sra r2 1", reg_word(cpu6_isa_pkg::OP_SRA, 13, 2, 12), 32'h091a_2b3c, 13);
   add_vec("amount 17", imm_word(cpu6_isa_pkg::OP_ADDI, 12, 0, 20'h00011), 32'd17, 12);
   add_vec("sll r2 17", reg_word(cpu6_isa_pkg::OP_SLL, 13, 2, 12), 32'hacf0_0000, 13);
   add_vec("srl r1 17", reg_word(cpu6_isa_pkg::OP_SRL, 13, 1, 12), 32'h0000_43b2, 13);
   add_vec("sra r1 17", reg_word(cpu6_isa_pkg::OP_SRA, 13, 1, 12), 32'hffff_c3b2, 13);
   add_vec("sra r2 17", reg_word(cpu6_isa_pkg::OP_SRA, 13, 2, 12), 32'h0000_091a, 13);
   add_vec("amount 63", imm_word(cpu6_isa_pkg::OP_ADDI, 12, 0, 20'h0003f), 32'h0000_003f, 12);
   add_vec("sll r1 31", reg_word(cpu6_isa_pkg::OP_SLL, 13, 1, 12), 32'h8000_0000, 13);
   add_vec("srl r1 31", reg_word(cpu6_isa_pkg::OP_SRL, 13, 1, 12), 32'h0000_0001, 13);
   add_vec("sra r1 31", reg_word(cpu6_isa_pkg::OP_SRA, 13, 1, 12), 32'hffff_ffff, 13);
   add_vec("srl r2 31", reg_word(cpu6_isa_pkg::OP_SRL, 13, 2, 12), 32'd0, 13);

   // immediate shifts
   add_vec("slli r1 0", imm_word(cpu6_isa_pkg::OP_SLLI, 14, 1, 20'h00000), 32'h8765_4321, 14);
   add_vec("srai r1 0", imm_word(cpu6_isa_pkg::OP_SRAI, 14, 1, 20'h00000), 32'h8765_4321, 14);
   add_vec("slli r2 4", imm_word(cpu6_isa_pkg::OP_SLLI, 14, 2, 20'h00004), 32'h2345_6780, 14);
   add_vec("srli r1 4", imm_word(cpu6_isa_pkg::OP_SRLI, 14, 1, 20'h00004), 32'h0876_5432, 14);
   add_vec("srai r1 4", imm_word(cpu6_isa_pkg::OP_SRAI, 14, 1, 20'h00004), 32'hf876_5432, 14);
   add_vec("slli r1 10", imm_word(cpu6_isa_pkg::OP_SLLI, 14, 1, 20'h0000a), 32'h950c_8400, 14);
   add_vec("srli r1 10", imm_word(cpu6_isa_pkg::OP_SRLI, 14, 1, 20'h0000a), 32'h0021_d950, 14);
   add_vec("srai r1 10", imm_word(cpu6_isa_pkg::OP_SRAI, 14, 1, 20'h0000a), 32'hffe1_d950, 14);
   add_vec("slli r1 15", imm_word(cpu6_isa_pkg::OP_SLLI, 14, 1, 20'h0000f), 32'ha190_8000, 14);
   add_vec("srli r2 15", imm_word(cpu6_isa_pkg::OP_SRLI, 14, 2, 20'h0000f), 32'h0000_2468, 14);
   add_vec("srai r1 15", imm_word(cpu6_isa_pkg::OP_SRAI, 14, 1, 20'h0000f), 32'hffff_0eca, 14);
   add_vec("srli r1 16", imm_word(cpu6_isa_pkg::OP_SRLI, 14, 1, 20'h00010), 32'h0000_8765, 14);
   add_vec("srai r1 16", imm_word(cpu6_isa_pkg::OP_SRAI, 14, 1, 20'h00010), 32'hffff_8765, 14);
   add_vec("slli r2 16", imm_word(cpu6_isa_pkg::OP_SLLI, 14, 2, 20'h00010), 32'h5678_0000, 14);
   add_vec("srai r2 16", imm_word(cpu6_isa_pkg::OP_SRAI, 14, 2, 20'h00010), 32'h0000_1234, 14);
   add_vec("slli r2 31", imm_word(cpu6_isa_pkg::OP_SLLI, 14, 2, 20'h0001f), 32'd0, 14);
   add_vec("srai r1 31", imm_word(cpu6_isa_pkg::OP_SRAI, 14, 1, 20'h0001f), 32'hffff_ffff, 14);
   add_vec("srai high imm", imm_word(cpu6_isa_pkg::OP_SRAI, 14, 1, 20'hfffe1), 32'hc3b2_a190, 14);

   // r0 writes are reported but dropped
   add_vec("add to r0", reg_word(cpu6_isa_pkg::OP_ADD, 0, 1, 2), 32'h9999_9999, 0);
   add_vec("read r0", reg_word(cpu6_isa_pkg::OP_ADD, 15, 0, 4), 32'd7, 15);

   // reserved opcodes leave rd alone
   add_vec("reserved e", reg_word(4'he, 4, 1, 2), 32'd0, 4);
   add_vec("r4 kept", imm_word(cpu6_isa_pkg::OP_ADDI, 15, 4, 20'h00000), 32'd7, 15);
   add_vec("reserved f", reg_word(4'hf, 1, 2, 3), 32'd0, 1);
   add_vec("r1 kept", reg_word(cpu6_isa_pkg::OP_OR, 15, 1, 0), 32'h8765_4321, 15);
endtask

// ==== testbench/tb_cpu6_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu6_top;

   localparam int PERIOD     = 40;
   localparam int RST_CYCLES = 8;
   localparam int DRV        = 2;   // drive delay after the rising edge

   logic        clk;
   logic        rst;
   logic        instr_valid;
   logic [31:0] instr;
   logic        res_ready;
   logic        instr_ready;
   logic        res_valid;
   logic [31:0] res_data;
   logic [3:0]  res_rd;

   logic [31:0] vec_instr[$];
   logic [31:0] vec_data[$];
   logic [3:0]  vec_rd[$];
   string       vec_name[$];

   int n_vec     = 0;
   int n_done    = 0;

   cpu6_top dut0 (
      .clk         (clk),
      .rst         (rst),
      .instr_valid (instr_valid),
      .instr       (instr),
      .res_ready   (res_ready),
      .instr_ready (instr_ready),
      .res_valid   (res_valid),
      .res_data    (res_data),
      .res_rd      (res_rd)
   );

   always #(PERIOD / 2) clk = ~clk;

   function automatic logic [31:0] reg_word(input logic [3:0] op, input int rd,
                                            input int rs1, input int rs2);
      return {op, rd[3:0], rs1[3:0], rs2[3:0], 16'h0000};
   endfunction

   function automatic logic [31:0] imm_word(input logic [3:0] op, input int rd,
                                            input int rs1, input logic [19:0] imm);
      return {op, rd[3:0], rs1[3:0], imm};
   endfunction

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   task automatic add_vec(input string name, input logic [31:0] word,
                          input logic [31:0] data, input int rd);
      vec_name.push_back(name);
      vec_instr.push_back(word);
      vec_data.push_back(data);
      vec_rd.push_back(rd[3:0]);
   endtask

   `include "tb_cpu6_vectors.svh"

   task automatic stop_run();
      $display("=== FAIL ===");
      $fatal(1);
   endtask

   task automatic abort_run(input string why);
      $display("ERROR: %s", why);
      stop_run();
   endtask

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (actual !== expected) begin
         $display("[FAIL] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
         stop_run();
      end
   endtask

   // holds the word until taken with ready sampled mid-cycle
   task automatic offer(input logic [31:0] word);
      logic taken;
      taken       = 1'b0;
      instr_valid = 1'b1;
      instr       = word;
      while (!taken) begin
         @(negedge clk);
         taken = instr_ready;
         @(posedge clk);
         #DRV;
      end
   endtask

   initial begin
      clk         = 1'b0;
      rst         = 1'b1;
      instr_valid = 1'b0;
      instr       = '0;
      load_vectors();
      n_vec = vec_instr.size();
      repeat (RST_CYCLES) @(posedge clk);
      #DRV;
      rst = 1'b0;
      @(negedge clk);
      check("reset res_valid", 32'd0, {31'd0, res_valid});
      check("reset instr_ready", 32'd1, {31'd0, instr_ready});
      @(posedge clk);
      #DRV;
      for (int i = 0; i < n_vec; i++) begin
         offer(vec_instr[i]);
      end
      instr_valid = 1'b0;
      instr       = '0;
      wait (n_done == n_vec);
      repeat (4) @(posedge clk); // room for a stray extra result
      $display("=== PASS ===");
      $finish;
   end

   // random back-pressure with about one stall in four
   initial begin : backpressure
      logic [31:0] seed;
      seed      = 32'd27790;
      res_ready = 1'b0;
      forever begin
         @(posedge clk);
         #DRV;
         seed      = lcg_next(seed);
         res_ready = (seed[17:16] != 2'b00);
      end
   end

   initial begin : monitor
      logic        holding;
      logic [31:0] held_data;
      logic [3:0]  held_rd;
      holding = 1'b0;
      forever begin
         @(negedge clk);
         if (!rst) begin
            if (holding && !res_valid) begin
               abort_run("res_valid dropped while the result was stalled");
            end
            if (holding) begin
               check({vec_name[n_done], " hold data"}, held_data, res_data);
               check({vec_name[n_done], " hold rd"}, {28'd0, held_rd}, {28'd0, res_rd});
            end
            if (res_valid && res_ready) begin
               if (n_done >= n_vec) begin
                  abort_run("more results arrived than instructions were issued");
               end
               check({vec_name[n_done], " data"}, vec_data[n_done], res_data);
               check({vec_name[n_done], " rd"}, {28'd0, vec_rd[n_done]}, {28'd0, res_rd});
               n_done++;
               holding = 1'b0;
            end else if (res_valid) begin
               holding   = 1'b1;
               held_data = res_data;
               held_rd   = res_rd;
            end
         end
      end
   end

   initial begin : watchdog
      wait (n_vec > 0);
      #((n_vec * 20 + RST_CYCLES) * PERIOD);
      $display("ERROR: results stopped arriving, %0d of %0d checked", n_done, n_vec);
      stop_run();
   end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+testbench
design/cpu6_dp_pkg.sv
design/cpu6_isa_pkg.sv
design/cpu6_regfile.sv
design/cpu6_shft.sv
design/cpu6_alu.sv
design/cpu6_exu.sv
design/cpu6_top.sv
testbench/tb_cpu6_top.sv
